// ==== Makefile ====
# Verilator build and run of the video path testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module video_tb -o video_sim
	out=$$(./obj_dir/video_sim); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+logic
logic/video_pkg.sv
logic/reg_bus_if.sv
logic/display_control.sv
logic/bitplane_shifter.sv
logic/sprite_shifter.sv
logic/pixel_compositor.sv
logic/video_top.sv
verification/video_tb.sv

// ==== logic/bitplane_shifter.sv ====
// -------------------------------------
// four bitplane holding registers and shifters
// bpl1dat write reloads all planes, gives a 4 bit playfield index
// -------------------------------------
`include "video_params.svh"

module bitplane_shifter import video_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  reg_bus_if.unit           bus,
  input  logic [`BPU_W-1:0] bpu,         // planes in use, from bplcon0
  output plf_index_t        plf_index
);

  localparam int PLANE_W = $clog2(`NUM_PLANES);

  logic [`DATA_W-1:0] hold  [`NUM_PLANES];   // words waiting for bpl1dat
  logic [`DATA_W-1:0] shift [`NUM_PLANES];   // msb is current pixel
  logic [`BPU_W-1:0]  l_bpu;                 // bpu as of last bpl1dat
  logic               load_pend;             // copy hold into shifters
  logic               bpl_wr;
  logic               bpl1_wr;

  assign bpl_wr  = bus.pix_en && (bus.sel == REG_BPLDAT);
  assign bpl1_wr = bpl_wr && (bus.sub == 4'd0);

  // -------------------------------------
  // holding registers
  // -------------------------------------
  always_ff @(posedge clk) begin
    if (bpl_wr)
      hold[bus.sub[PLANE_W-1:0]] <= bus.data;
  end

  // -------------------------------------
  // shifters, one pixel per enabled cycle
  // -------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      load_pend <= 1'b0;
      l_bpu     <= `BPU_RESET;
      for (int p = 0; p < `NUM_PLANES; p++)
        shift[p] <= '0;                         // empty, index 0
    end else if (bus.pix_en) begin
      load_pend <= bpl1_wr;
      if (bpl1_wr)
        l_bpu <= bpu;
      for (int p = 0; p < `NUM_PLANES; p++) begin
        if (load_pend)
          shift[p] <= hold[p];                  // parallel load
        else
          shift[p] <= {shift[p][`DATA_W-2:0], 1'b0};   // zeros after 16
      end
    end
  end

  // planes at or above bpu read as zero
  always_comb begin
    for (int p = 0; p < `NUM_PLANES; p++)
      plf_index[p] = shift[p][`DATA_W-1] && (p < l_bpu);
  end

  // bplcon0 never asks for more planes than the shifter holds
  a_bpu_range: assert property (@(posedge clk) disable iff (reset)
    bpl1_wr |-> bpu <= `NUM_PLANES);

endmodule

// ==== logic/display_control.sv ====
// -------------------------------------
// address decode, beam counter and display window
// holds bplcon0/bplcon2 and drives the register bus to the pixel blocks
// -------------------------------------
`include "video_params.svh"

module display_control import video_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               clk7_en,
  input  logic               strhor,        // start of line
  input  logic [`ADDR_W-1:0] reg_address,
  input  logic [`DATA_W-1:0] data_in,
  reg_bus_if.ctrl            bus,
  output logic               window,        // inside horizontal window
  output logic               pf_pri,        // playfield over sprite
  output logic [`BPU_W-1:0]  bpu,           // planes in use
  output logic [`DATA_W-1:0] id_out
);

  reg_sel_e           sel;
  logic [`ADDR_W-1:0] offs;        // address minus base of its range
  logic [`HPOS_W-1:0] hpos;
  logic [`HPOS_W-1:0] diw_start;
  logic [`HPOS_W-1:0] diw_stop;

  // -------------------------------------
  // address decode
  // -------------------------------------
  always_comb begin
    sel  = REG_NONE;
    offs = '0;
    case (reg_address) inside
      `ADDR_DIWSTRT:  sel = REG_DIWSTRT;
      `ADDR_DIWSTOP:  sel = REG_DIWSTOP;
      `ADDR_BPLCON0:  sel = REG_BPLCON0;
      `ADDR_BPLCON2:  sel = REG_BPLCON2;
      `ADDR_BPL1DAT, `ADDR_BPL2DAT, `ADDR_BPL3DAT, `ADDR_BPL4DAT: begin
        sel  = REG_BPLDAT;
        offs = reg_address - `ADDR_BPL1DAT;   // plane 0..3
      end
      `ADDR_SPR0POS:  sel = REG_SPRPOS;
      `ADDR_SPR0DATA: sel = REG_SPRDATA;
      `ADDR_SPR0DATB: sel = REG_SPRDATB;
      [`ADDR_COLOR00 : `ADDR_COLOR00 + `NUM_COLORS - 1]: begin
        sel  = REG_COLOR;
        offs = reg_address - `ADDR_COLOR00;   // colour 0..15
      end
      `ADDR_CLXDAT:   sel = REG_CLXDAT;
      `ADDR_DENISEID: sel = REG_ID;
      default:        sel = REG_NONE;         // idle or unmapped
    endcase
  end

  assign bus.sel    = sel;
  assign bus.sub    = offs[3:0];
  assign bus.data   = data_in;
  assign bus.hpos   = hpos;
  assign bus.pix_en = clk7_en;

  // beam counter, restarts at 2 like the real chip
  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= `HPOS_START;
    end else if (clk7_en) begin
      if (strhor)
        hpos <= `HPOS_START;
      else
        hpos <= hpos + 1'b1;
    end
  end

  // -------------------------------------
  // control registers
  // -------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      bpu       <= `BPU_RESET;
      pf_pri    <= 1'b0;
      diw_start <= `DIW_RESET;
      diw_stop  <= `DIW_RESET;
    end else if (clk7_en) begin
      case (sel)
        REG_BPLCON0: bpu       <= data_in[`BPU_LSB +: `BPU_W];
        REG_BPLCON2: pf_pri    <= data_in[`PF_PRI_BIT];
        REG_DIWSTRT: diw_start <= {1'b0, data_in[7:0]};   // h8 is 0
        REG_DIWSTOP: diw_stop  <= {1'b1, data_in[7:0]};   // h8 is 1
        default: ;
      endcase
    end
  end

  // window opens the cycle after start, closes the cycle after stop
  always_ff @(posedge clk) begin
    if (reset) begin
      window <= 1'b0;
    end else if (clk7_en) begin
      if (hpos == diw_stop)
        window <= 1'b0;           // equal limits give an empty window
      else if (hpos == diw_start)
        window <= 1'b1;
    end
  end

  assign id_out = (sel == REG_ID) ? `DENISE_ID : '0;

  // pixel blocks only ever see a known target on an enabled cycle
  a_sel_known: assert property (@(posedge clk) disable iff (reset)
    clk7_en |-> !$isunknown(sel) && (sel <= REG_ID));

endmodule

// ==== logic/pixel_compositor.sv ====
// -------------------------------------
// sprite/playfield priority, colour table and output register
// also the collision latch and the read data mux
// -------------------------------------
`include "video_params.svh"

module pixel_compositor import video_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               blank,       // forces black
  reg_bus_if.unit            bus,
  input  logic               window,
  input  logic               pf_pri,      // playfield in front of sprite
  input  plf_index_t         plf_index,
  input  spr_index_t         spr_index,
  input  logic [`DATA_W-1:0] id_out,
  output logic [`DATA_W-1:0] data_out,
  output logic [3:0]         red,
  output logic [3:0]         green,
  output logic [3:0]         blue
);

  // sprite colours 17..19 fold onto 13..15 with one sprite
  localparam plf_index_t SPR_BASE = 4'd12;

  rgb12_t     ctab [`NUM_COLORS];   // colour table
  rgb12_t     rgb_q;                // registered output pixel
  plf_index_t col_num;
  logic       spr_front;            // sprite wins this pixel
  logic       overlap;
  logic       clx;                  // sprite 0 hit playfield
  logic       clx_rd;

  // -------------------------------------
  // colour table
  // -------------------------------------
  always_ff @(posedge clk) begin
    if (bus.pix_en && (bus.sel == REG_COLOR))
      ctab[bus.sub] <= rgb12_t'(bus.data[11:0]);
  end

  // -------------------------------------
  // priority and lookup
  // -------------------------------------
  assign spr_front = (spr_index != 2'd0) && (!pf_pri || (plf_index == 4'd0));

  always_comb begin
    if (!window)
      col_num = 4'd0;
    else if (spr_front)
      col_num = SPR_BASE + {2'b00, spr_index};
    else
      col_num = plf_index;
  end

  // border is black, blank wins in the same stage
  always_ff @(posedge clk) begin
    if (reset) begin
      rgb_q <= '0;
    end else if (bus.pix_en) begin
      if (blank || !window)
        rgb_q <= '0;
      else
        rgb_q <= ctab[col_num];
    end
  end

  assign red   = rgb_q.r;
  assign green = rgb_q.g;
  assign blue  = rgb_q.b;

  // -------------------------------------
  // collision and read back
  // -------------------------------------
  assign overlap = window && (spr_index != 2'd0) && (plf_index != 4'd0);
  assign clx_rd  = (bus.sel == REG_CLXDAT);

  always_ff @(posedge clk) begin
    if (reset) begin
      clx <= 1'b0;
    end else if (bus.pix_en) begin
      if (overlap)
        clx <= 1'b1;          // new hit beats the clear
      else if (clx_rd)
        clx <= 1'b0;          // clear on read
    end
  end

  assign data_out = (clx_rd ? {{(`DATA_W-1){1'b0}}, clx} : '0) | id_out;

  // blank on an enabled cycle shows as black one edge later
  a_blank_black: assert property (@(posedge clk) disable iff (reset)
    blank && bus.pix_en |=> rgb_q == '0);

endmodule

// ==== logic/reg_bus_if.sv ====
// -------------------------------------
// decoded register bus and beam position
// driven by display_control, read by the pixel blocks
// -------------------------------------
`include "video_params.svh"

interface reg_bus_if import video_pkg::*; ();

  reg_sel_e             sel;      // decoded target, REG_NONE when idle
  logic [3:0]           sub;      // plane or colour number
  logic [`DATA_W-1:0]   data;     // write data
  logic [`HPOS_W-1:0]   hpos;     // beam counter
  logic                 pix_en;   // pixel enable

  // a write is pix_en high with sel other than REG_NONE, no ack

  modport ctrl (
    output sel, sub, data, hpos, pix_en
  );

  modport unit (
    input sel, sub, data, hpos, pix_en
  );

endinterface

// ==== logic/sprite_shifter.sv ====
// -------------------------------------
// single 16 pixel sprite, two bits a pixel
// armed by spr0data, started when the beam hits spr0pos
// -------------------------------------
`include "video_params.svh"

module sprite_shifter import video_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  reg_bus_if.unit bus,
  output spr_index_t spr_index
);

  logic [`HPOS_W-1:0] spr_pos;    // horizontal start
  logic [`DATA_W-1:0] data_a;     // low index bit
  logic [`DATA_W-1:0] data_b;     // high index bit
  logic [`DATA_W-1:0] shift_a;
  logic [`DATA_W-1:0] shift_b;
  logic               armed;
  logic               hit;        // beam at start while armed

  assign hit = armed && (bus.hpos == spr_pos);

  // -------------------------------------
  // position and data words
  // -------------------------------------
  always_ff @(posedge clk) begin
    if (bus.pix_en) begin
      case (bus.sel)
        REG_SPRPOS:  spr_pos <= bus.data[`HPOS_W-1:0];
        REG_SPRDATA: data_a  <= bus.data;
        REG_SPRDATB: data_b  <= bus.data;
        default: ;
      endcase
    end
  end

  // data write arms, position write disarms
  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
    end else if (bus.pix_en) begin
      if (bus.sel == REG_SPRPOS)
        armed <= 1'b0;
      else if (bus.sel == REG_SPRDATA)
        armed <= 1'b1;
    end
  end

  // -------------------------------------
  // shifters
  // -------------------------------------
  // pixel 0 goes out straight from the data words on the hit cycle,
  // the shifters pick up from pixel 1
  always_ff @(posedge clk) begin
    if (reset) begin
      shift_a <= '0;
      shift_b <= '0;
    end else if (bus.pix_en) begin
      if (hit) begin
        shift_a <= {data_a[`DATA_W-2:0], 1'b0};
        shift_b <= {data_b[`DATA_W-2:0], 1'b0};
      end else begin
        shift_a <= {shift_a[`DATA_W-2:0], 1'b0};   // drains to transparent
        shift_b <= {shift_b[`DATA_W-2:0], 1'b0};
      end
    end
  end

  assign spr_index = hit ? {data_b[`DATA_W-1], data_a[`DATA_W-1]}
                         : {shift_b[`DATA_W-1], shift_a[`DATA_W-1]};

endmodule

// ==== logic/video_params.svh ====
// -------------------------------------
// register map and constants of the video path
// included by every block that decodes or sizes bus fields
// -------------------------------------
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// bus widths
`define ADDR_W        8
`define DATA_W        16

// word addresses, 0 is an idle bus
`define ADDR_CLXDAT   8'h07     // collision read, clears on read
`define ADDR_DENISEID 8'h3e
`define ADDR_DIWSTRT  8'h47
`define ADDR_DIWSTOP  8'h48
`define ADDR_BPLCON0  8'h80
`define ADDR_BPLCON2  8'h82
`define ADDR_BPL1DAT  8'h88     // written last, starts the shifters
`define ADDR_BPL2DAT  8'h89
`define ADDR_BPL3DAT  8'h8a
`define ADDR_BPL4DAT  8'h8b
`define ADDR_SPR0POS  8'ha0
`define ADDR_SPR0DATA 8'ha2
`define ADDR_SPR0DATB 8'ha3
`define ADDR_COLOR00  8'hc0     // 16 entries, up to 8'hcf

// field widths and bit positions
`define HPOS_W        9
`define HPOS_START    9'd2      // beam value after strhor
`define NUM_PLANES    4
`define NUM_COLORS    16
`define BPU_LSB       12        // bplcon0[14:12]
`define BPU_W         3
`define PF_PRI_BIT    6         // bplcon2, playfield in front

// reset and fixed values
`define BPU_RESET     3'd0
`define DIW_RESET     9'h000
`define DENISE_ID     16'hffff

`endif

// ==== logic/video_pkg.sv ====
// -------------------------------------
// types shared by the video path blocks
// register targets, colour word and pixel index types
// -------------------------------------
package video_pkg;

  // decoded register target, one per register group
  typedef enum logic [3:0] {
    REG_NONE    = 4'd0,   // bus idle
    REG_DIWSTRT = 4'd1,
    REG_DIWSTOP = 4'd2,
    REG_BPLCON0 = 4'd3,
    REG_BPLCON2 = 4'd4,
    REG_BPLDAT  = 4'd5,   // sub gives plane number
    REG_SPRPOS  = 4'd6,
    REG_SPRDATA = 4'd7,
    REG_SPRDATB = 4'd8,
    REG_COLOR   = 4'd9,   // sub gives colour number
    REG_CLXDAT  = 4'd10,
    REG_ID      = 4'd11
  } reg_sel_e;

  // 12 bit ocs colour, 4 bits a channel
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb12_t;

  typedef logic [3:0] plf_index_t;   // one bit per bitplane
  typedef logic [1:0] spr_index_t;   // {datb, data} bit, 0 = transparent

endpackage

// ==== logic/video_top.sv ====
// -------------------------------------
// top of the video path
// register bus in, 12 bit rgb out, blocks joined by reg_bus_if
// -------------------------------------
`include "video_params.svh"

module video_top import video_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               clk7_en,      // pixel enable
  input  logic               strhor,       // line start strobe
  input  logic               blank,
  input  logic [`ADDR_W-1:0] reg_address,  // word address, 0 = idle
  input  logic [`DATA_W-1:0] data_in,
  output logic [`DATA_W-1:0] data_out,
  output logic [3:0]         red,
  output logic [3:0]         green,
  output logic [3:0]         blue
);

  logic               window;
  logic               pf_pri;
  logic [`BPU_W-1:0]  bpu;
  logic [`DATA_W-1:0] id_out;
  plf_index_t         plf_index;
  spr_index_t         spr_index;

  reg_bus_if bus ();

  display_control display_control_inst (
    .clk         (clk),
    .reset       (reset),
    .clk7_en     (clk7_en),
    .strhor      (strhor),
    .reg_address (reg_address),
    .data_in     (data_in),
    .bus         (bus.ctrl),
    .window      (window),
    .pf_pri      (pf_pri),
    .bpu         (bpu),
    .id_out      (id_out)
  );

  bitplane_shifter bitplane_shifter_inst (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus.unit),
    .bpu       (bpu),
    .plf_index (plf_index)
  );

  sprite_shifter sprite_shifter_inst (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus.unit),
    .spr_index (spr_index)
  );

  pixel_compositor pixel_compositor_inst (
    .clk       (clk),
    .reset     (reset),
    .blank     (blank),
    .bus       (bus.unit),
    .window    (window),
    .pf_pri    (pf_pri),
    .plf_index (plf_index),
    .spr_index (spr_index),
    .id_out    (id_out),
    .data_out  (data_out),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

endmodule

// ==== verification/video_tb.sv ====
// ----------------------------------------
// directed testbench for video_top
// one task per test, lines captured into an array and checked
// ----------------------------------------
`include "video_params.svh"

module video_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LINE_LEN  = 300;
  localparam int WIN_START = 100;            // diwstrt low byte
  localparam int WIN_STOP  = 256 + 4;        // diwstop, h8 always set
  localparam int BPL_WR_AT = 150;            // bpl1dat write, inside window
  // first playfield pixel in cycle w+2, hpos there is w+3
  localparam int SPR_AT    = BPL_WR_AT + 3;
  localparam logic [15:0] SPR_DATA = 16'hcccc;
  localparam logic [15:0] SPR_DATB = 16'hf0f0;
  // pixel k gets index 15-k, all 16 distinct
  localparam logic [15:0] PLANE_WORD [4] = '{16'haaaa, 16'hcccc, 16'hf0f0, 16'hff00};

  logic        clk;
  logic        reset;
  logic        clk7_en;
  logic        strhor;
  logic        blank;
  logic [7:0]  reg_address;
  logic [15:0] data_in;
  logic [15:0] data_out;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;

  logic [11:0] line_rgb [LINE_LEN];   // captured line
  logic [11:0] ref_rgb  [LINE_LEN];
  logic [11:0] colors   [16];         // expected colour table
  int          seed = 32'h61f0_1900;
  int          errors;
  int          checks;
  int          test_errors;
  int          ev_cycle [$];          // writes issued during a line
  logic [7:0]  ev_addr  [$];
  logic [15:0] ev_data  [$];
  int          blank_from = -1;
  int          blank_to   = -1;

  video_top video_top_inst (
    .clk(clk), .reset(reset), .clk7_en(clk7_en), .strhor(strhor), .blank(blank),
    .reg_address(reg_address), .data_in(data_in), .data_out(data_out),
    .red(red), .green(green), .blue(blue)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 50 MHz
  end

  // ----------------------------------------
  // bus and line tasks
  // ----------------------------------------
  task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
    @(posedge clk);
    reg_address <= addr;
    data_in     <= data;
    @(posedge clk);
    reg_address <= 8'h00;   // back to idle
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [15:0] data);
    @(posedge clk);
    reg_address <= addr;
    @(negedge clk);
    data = data_out;        // combinational from address
    @(posedge clk);
    reg_address <= 8'h00;
  endtask

  task automatic set_color(input int idx, input logic [11:0] rgb);
    write_reg(8'(`ADDR_COLOR00 + idx), {4'h0, rgb});
    colors[idx] = rgb;
  endtask

  task automatic add_write(input int cycle, input logic [7:0] addr, input logic [15:0] data);
    ev_cycle.push_back(cycle);
    ev_addr.push_back(addr);
    ev_data.push_back(data);
  endtask

  // first pass only settles the beam and window, second pass is kept
  task automatic run_line();
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < LINE_LEN; i++) begin
        @(posedge clk);
        strhor      <= (i == 0);
        blank       <= (pass == 1) && (i >= blank_from) && (i <= blank_to);
        reg_address <= 8'h00;
        data_in     <= 16'h0000;
        for (int e = 0; e < ev_cycle.size(); e++) begin
          if (pass == 1 && ev_cycle[e] == i) begin
            reg_address <= ev_addr[e];
            data_in     <= ev_data[e];
          end
        end
        @(negedge clk);
        if (pass == 1)
          line_rgb[i] = {red, green, blue};   // pixel of the previous cycle
      end
    end
    @(posedge clk);
    strhor      <= 1'b0;
    blank       <= 1'b0;
    reg_address <= 8'h00;
    ev_cycle.delete();
    ev_addr.delete();
    ev_data.delete();
    blank_from = -1;
    blank_to   = -1;
  endtask

  // ----------------------------------------
  // checking helpers
  // ----------------------------------------
  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
    test_errors = 0;
  endtask

  // bounded search for the first sample that is neither border nor black
  task automatic find_pixels(input int from, output int idx);
    idx = -1;
    for (int i = from; i < LINE_LEN - 17; i++) begin
      if (idx < 0 && line_rgb[i] !== 12'h000 && line_rgb[i] !== colors[0])
        idx = i;
    end
    if (idx < 0) begin
      errors++;
      test_errors++;
      $display("timeout: no pixel other than the border colour after sample %0d", from);
    end
  endtask

  // low nibble is the colour number, so entries never collide or read as 0
  function automatic logic [11:0] random_color(input int c);
    logic [31:0] r;
    r = $random(seed);
    return {r[11:8] | 4'h1, r[7:4], 4'(c)};
  endfunction

  function automatic logic [3:0] plane_index(input int k, input int planes);
    logic [3:0] idx;
    idx = 4'd0;
    for (int p = 0; p < planes; p++)
      idx[p] = PLANE_WORD[p][15 - k];   // msb first
    return idx;
  endfunction

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic test_reset_id();
    logic [15:0] rd;
    int          lit;
    lit = 0;
    run_line();
    foreach (line_rgb[i])
      if (line_rgb[i] !== 12'h000) lit++;
    check("reset_id", 0, lit);
    read_reg(`ADDR_DENISEID, rd);
    check("reset_id", 16'hffff, rd);
    read_reg(`ADDR_CLXDAT, rd);
    check("reset_id", 16'h0000, rd);
    finish_test("reset_id");
  endtask

  task automatic test_window_border();
    int count;
    int other;
    int first;
    int last;
    count = 0;
    other = 0;
    first = -1;
    last  = -1;
    write_reg(`ADDR_BPLCON0, 16'h0000);      // no planes
    set_color(0, random_color(0));
    write_reg(`ADDR_DIWSTRT, 16'(WIN_START));
    write_reg(`ADDR_DIWSTOP, 16'(WIN_STOP - 256));
    run_line();
    foreach (line_rgb[i]) begin
      if (line_rgb[i] === colors[0]) begin
        count++;
        if (first < 0) first = i;
        last = i;
      end else if (line_rgb[i] !== 12'h000) begin
        other++;
      end
    end
    check("window_border", WIN_STOP - WIN_START, count);
    check("window_border", 0, other);
    check("window_border", WIN_STOP - WIN_START, last - first + 1);   // no gap
    finish_test("window_border");
  endtask

  task automatic compare_planes(input string name, input int planes);
    int start;
    find_pixels(BPL_WR_AT, start);
    if (start >= 0) begin
      for (int k = 0; k < 16; k++)
        check(name, colors[plane_index(k, planes)], line_rgb[start + k]);
      check(name, colors[0], line_rgb[start + 16]);   // shifters drained
    end
  endtask

  task automatic test_bitplanes();
    for (int c = 1; c < 16; c++)
      set_color(c, random_color(c));
    write_reg(`ADDR_BPLCON0, 16'h4000);      // 4 planes
    write_reg(`ADDR_BPL2DAT, PLANE_WORD[1]);
    write_reg(`ADDR_BPL3DAT, PLANE_WORD[2]);
    write_reg(`ADDR_BPL4DAT, PLANE_WORD[3]);
    add_write(BPL_WR_AT, `ADDR_BPL1DAT, PLANE_WORD[0]);
    run_line();
    compare_planes("bitplanes_4", 4);
    write_reg(`ADDR_BPLCON0, 16'h2000);      // 2 planes, upper ones masked
    add_write(BPL_WR_AT, `ADDR_BPL1DAT, PLANE_WORD[0]);
    run_line();
    compare_planes("bitplanes_2", 2);
    finish_test("bitplanes");
  endtask

  task automatic compare_sprite(input string name, input logic pri);
    int         start;
    logic [1:0] spr;
    find_pixels(BPL_WR_AT, start);
    if (start >= 0) begin
      for (int k = 0; k < 16; k++) begin
        spr = {SPR_DATB[15 - k], SPR_DATA[15 - k]};
        // playfield index is 1 under the whole sprite
        check(name, (spr != 2'd0 && !pri) ? colors[12 + spr] : colors[1],
              line_rgb[start + k]);
      end
      check(name, colors[0], line_rgb[start + 16]);
    end
  endtask

  task automatic test_sprite_priority();
    write_reg(`ADDR_BPLCON0, 16'h1000);      // one solid plane
    write_reg(`ADDR_BPLCON2, 16'h0000);      // sprite in front
    write_reg(`ADDR_SPR0POS, 16'(SPR_AT));
    write_reg(`ADDR_SPR0DATB, SPR_DATB);
    write_reg(`ADDR_SPR0DATA, SPR_DATA);     // arms
    add_write(BPL_WR_AT, `ADDR_BPL1DAT, 16'hffff);
    run_line();
    compare_sprite("sprite_front", 1'b0);
    write_reg(`ADDR_BPLCON2, 16'h0040);      // playfield in front
    add_write(BPL_WR_AT, `ADDR_BPL1DAT, 16'hffff);
    run_line();
    compare_sprite("playfield_front", 1'b1);
    finish_test("sprite_priority");
  endtask

  task automatic test_collision();
    logic [15:0] rd;
    int          lit;
    lit = 0;
    read_reg(`ADDR_CLXDAT, rd);
    check("collision", 16'h0001, rd);
    read_reg(`ADDR_CLXDAT, rd);
    check("collision", 16'h0000, rd);        // cleared by the first read
    // sprite and playfield overlap again, but left of the window
    write_reg(`ADDR_SPR0POS, 16'd50);
    write_reg(`ADDR_SPR0DATA, SPR_DATA);
    add_write(46, `ADDR_BPL1DAT, 16'hffff);
    run_line();
    for (int i = 0; i <= WIN_START; i++)
      if (line_rgb[i] !== 12'h000) lit++;
    check("collision", 0, lit);
    read_reg(`ADDR_CLXDAT, rd);
    check("collision", 16'h0000, rd);
    finish_test("collision");
  endtask

  task automatic test_blanking();
    int diff;
    int dark;
    int lit_ref;
    diff    = 0;
    dark    = 0;
    lit_ref = 0;
    run_line();
    ref_rgb = line_rgb;
    blank_from = 150;
    blank_to   = 169;
    run_line();
    foreach (line_rgb[i]) begin
      if (i >= 151 && i <= 170) begin       // blank shows one sample later
        if (line_rgb[i] !== 12'h000) dark++;
        if (ref_rgb[i] !== 12'h000) lit_ref++;
      end else if (line_rgb[i] !== ref_rgb[i]) begin
        diff++;
      end
    end
    check("blanking", 0, dark);
    check("blanking", 20, lit_ref);          // stretch is lit without blank
    check("blanking", 0, diff);
    finish_test("blanking");
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    reset       = 1'b1;
    clk7_en     = 1'b1;                      // pixel enable tied high
    strhor      = 1'b0;
    blank       = 1'b0;
    reg_address = 8'h00;
    data_in     = 16'h0000;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    test_reset_id();
    test_window_border();
    test_bitplanes();
    test_sprite_priority();
    test_collision();
    test_blanking();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule
